/* hw/fetch_decode_mapped.sv */
// Top level placing the fetch and decode stage in the data write address space
`timescale 1ns/1ns

module fetch_decode_mapped
    import fetch_decode_pkg::*;
#(
    parameter int im_depth                = 64,
    parameter int im_addr_width           = 6,
    parameter int thread_count            = 2,
    parameter int thread_count_width      = 1,
    parameter int od_thread_depth         = 16,
    parameter int im_base_addr_write      = 256,
    parameter int od_base_addr_write      = 512,
    parameter int db_base_addr            = 128,
    parameter int od_initial_thread_read  = 0,
    parameter int od_initial_thread_write = 1,
    parameter int write_retime_stages     = 1
)
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       ior_previous,
    input  logic                       cancel_previous,
    input  logic [addr_width-1:0]      write_addr,
    input  logic [word_width-1:0]      write_data,
    input  logic [im_addr_width-1:0]   im_read_addr,
    output logic [od_word_width-1:0]   alu_control,
    output logic [d_operand_width-1:0] da,
    output logic [d_operand_width-1:0] db,
    output logic [a_operand_width-1:0] a,
    output logic [b_operand_width-1:0] b
);

    logic                     im_wren;
    logic [im_addr_width-1:0] im_write_addr;
    logic [im_word_width-1:0] im_write_data;
    logic                     od_wren;
    logic [opcode_width-1:0]  od_write_addr;
    logic [od_word_width-1:0] od_write_data;

    write_address_mapper #(
        .im_depth            (im_depth),
        .im_addr_width       (im_addr_width),
        .od_thread_depth     (od_thread_depth),
        .im_base_addr_write  (im_base_addr_write),
        .od_base_addr_write  (od_base_addr_write),
        .write_retime_stages (write_retime_stages)
    ) write_address_mapper_inst (
        .clock           (clock),
        .rst_n           (rst_n),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .im_wren         (im_wren),
        .im_write_addr   (im_write_addr),
        .im_write_data   (im_write_data),
        .od_wren         (od_wren),
        .od_write_addr   (od_write_addr),
        .od_write_data   (od_write_data)
    );

    instruction_fetch_decode #(
        .im_depth                (im_depth),
        .im_addr_width           (im_addr_width),
        .thread_count            (thread_count),
        .thread_count_width      (thread_count_width),
        .od_thread_depth         (od_thread_depth),
        .od_initial_thread_read  (od_initial_thread_read),
        .od_initial_thread_write (od_initial_thread_write),
        .db_base_addr            (db_base_addr)
    ) instruction_fetch_decode_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .im_wren       (im_wren),
        .im_write_addr (im_write_addr),
        .im_write_data (im_write_data),
        .od_wren       (od_wren),
        .od_write_addr (od_write_addr),
        .od_write_data (od_write_data),
        .im_read_addr  (im_read_addr),
        .alu_control   (alu_control),
        .da            (da),
        .db            (db),
        .a             (a),
        .b             (b)
    );

endmodule

/* hw/fetch_decode_pkg.sv */
// Instruction format widths, machine word width and data write address width
package fetch_decode_pkg;

    // ----------------------------------------------------------------------
    // Data write bus
    // ----------------------------------------------------------------------

    localparam int word_width = 36;
    localparam int addr_width = 10;

    // ----------------------------------------------------------------------
    // Instruction format, listed from the top bit down
    // ----------------------------------------------------------------------

    localparam int opcode_width    = 4;
    localparam int d_operand_width = 10;
    localparam int a_operand_width = 10;
    localparam int b_operand_width = 10;

    // Full instruction word as stored in the instruction memory
    localparam int im_word_width = opcode_width + d_operand_width
                                  + a_operand_width + b_operand_width;

    // Control word produced by the opcode decoder table for the ALU
    localparam int od_word_width = 20;

endpackage

/* hw/instruction_fetch_decode.sv */
// Startup read disable, field split, operand alignment, B offset and both memories
`timescale 1ns/1ns

module instruction_fetch_decode
    import fetch_decode_pkg::*;
#(
    parameter int im_depth                = 64,
    parameter int im_addr_width           = 6,
    parameter int thread_count            = 2,
    parameter int thread_count_width      = 1,
    parameter int od_thread_depth         = 16,
    parameter int od_initial_thread_read  = 0,
    parameter int od_initial_thread_write = 1,
    parameter int db_base_addr            = 128
)
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       im_wren,
    input  logic [im_addr_width-1:0]   im_write_addr,
    input  logic [im_word_width-1:0]   im_write_data,
    input  logic                       od_wren,
    input  logic [opcode_width-1:0]    od_write_addr,
    input  logic [od_word_width-1:0]   od_write_data,
    input  logic [im_addr_width-1:0]   im_read_addr,
    output logic [od_word_width-1:0]   alu_control,
    output logic [d_operand_width-1:0] da,
    output logic [d_operand_width-1:0] db,
    output logic [a_operand_width-1:0] a,
    output logic [b_operand_width-1:0] b
);

    localparam int a_lsb      = b_operand_width;
    localparam int d_lsb      = a_lsb + a_operand_width;
    localparam int opcode_lsb = d_lsb + d_operand_width;

    logic [1:0]                 rden_sr;
    logic                       im_rden;
    logic                       od_rden;
    logic [im_word_width-1:0]   instruction;
    logic [opcode_width-1:0]    opcode;
    logic [d_operand_width-1:0] d_field;
    logic [a_operand_width-1:0] a_field;
    logic [b_operand_width-1:0] b_field;

    // ----------------------------------------------------------------------
    // The first two PCs after reset are bogus, so both reads stay off and
    // the stage outputs zeros for them
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rden_sr <= 2'b00;
            od_rden <= 1'b0;
        end else begin
            rden_sr <= {rden_sr[0], 1'b1};
            od_rden <= im_rden;
        end
    end

    assign im_rden = rden_sr[1];

    instruction_memory #(
        .im_depth      (im_depth),
        .im_addr_width (im_addr_width)
    ) instruction_memory_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .wren       (im_wren),
        .write_addr (im_write_addr),
        .write_data (im_write_data),
        .rden       (im_rden),
        .read_addr  (im_read_addr),
        .read_data  (instruction)
    );

    // Fields from the top bit down are opcode, D, A, B
    assign opcode  = instruction[opcode_lsb +: opcode_width];
    assign d_field = instruction[d_lsb +: d_operand_width];
    assign a_field = instruction[a_lsb +: a_operand_width];
    assign b_field = instruction[0 +: b_operand_width];

    opcode_decoder_memory #(
        .thread_count            (thread_count),
        .thread_count_width      (thread_count_width),
        .od_thread_depth         (od_thread_depth),
        .od_initial_thread_read  (od_initial_thread_read),
        .od_initial_thread_write (od_initial_thread_write)
    ) opcode_decoder_memory_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .wren        (od_wren),
        .write_addr  (od_write_addr),
        .write_data  (od_write_data),
        .rden        (od_rden),
        .opcode      (opcode),
        .alu_control (alu_control)
    );

    // ----------------------------------------------------------------------
    // Operands wait one cycle to line up with alu_control
    // ----------------------------------------------------------------------

    // db is cleared with the others so the startup NOP stays all zero
    always_ff @(posedge clock) begin
        if (!rst_n || !od_rden) begin
            da <= '0;
            db <= '0;
            a  <= '0;
            b  <= '0;
        end else begin
            da <= d_field;
            db <= d_field + d_operand_width'(db_base_addr);
            a  <= a_field;
            b  <= b_field;
        end
    end

endmodule

/* hw/instruction_memory.sv */
// Shared instruction RAM with one write port and a registered, gated read port
`timescale 1ns/1ns

module instruction_memory
    import fetch_decode_pkg::*;
#(
    parameter int im_depth      = 64,
    parameter int im_addr_width = 6
)
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     wren,
    input  logic [im_addr_width-1:0] write_addr,
    input  logic [im_word_width-1:0] write_data,
    input  logic                     rden,
    input  logic [im_addr_width-1:0] read_addr,
    output logic [im_word_width-1:0] read_data
);

    logic [im_word_width-1:0] mem [im_depth];

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // A disabled read outputs all zero, which the decoder treats as a NOP.
    // Reading a location while it is written gives the old contents
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (rden) begin
            read_data <= mem[read_addr];
        end else begin
            read_data <= '0;
        end
    end

endmodule

/* hw/opcode_decoder_memory.sv */
// Per-thread opcode decoder RAM with rotating read and write thread counters
`timescale 1ns/1ns

module opcode_decoder_memory
    import fetch_decode_pkg::*;
#(
    parameter int thread_count            = 2,
    parameter int thread_count_width      = 1,
    parameter int od_thread_depth         = 16,
    parameter int od_initial_thread_read  = 0,
    parameter int od_initial_thread_write = 1
)
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     wren,
    input  logic [opcode_width-1:0]  write_addr,
    input  logic [od_word_width-1:0] write_data,
    input  logic                     rden,
    input  logic [opcode_width-1:0]  opcode,
    output logic [od_word_width-1:0] alu_control
);

    localparam int od_depth = thread_count * od_thread_depth;
    localparam logic [thread_count_width-1:0] last_thread =
        thread_count_width'(thread_count - 1);

    logic [od_word_width-1:0]      mem [od_depth];
    logic [thread_count_width-1:0] thread_read;
    logic [thread_count_width-1:0] thread_write;

    // ----------------------------------------------------------------------
    // Thread counters, one step per cycle, wrapping at thread_count
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_read  <= thread_count_width'(od_initial_thread_read);
            thread_write <= thread_count_width'(od_initial_thread_write);
        end else begin
            thread_read  <= (thread_read == last_thread) ? '0 : thread_read + 1'b1;
            thread_write <= (thread_write == last_thread) ? '0 : thread_write + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Table storage, addressed by thread index then opcode
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[{thread_write, write_addr}] <= write_data;
        end
    end

    // Read output is zero when disabled, like the instruction memory
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            alu_control <= '0;
        end else if (rden) begin
            alu_control <= mem[{thread_read, opcode}];
        end else begin
            alu_control <= '0;
        end
    end

endmodule

/* hw/write_address_mapper.sv */
// Store retiming, window checks and translated write strobes for both memories
`timescale 1ns/1ns

module write_address_mapper
    import fetch_decode_pkg::*;
#(
    parameter int im_depth            = 64,
    parameter int im_addr_width       = 6,
    parameter int od_thread_depth     = 16,
    parameter int im_base_addr_write  = 256,
    parameter int od_base_addr_write  = 512,
    parameter int write_retime_stages = 1
)
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     ior_previous,
    input  logic                     cancel_previous,
    input  logic [addr_width-1:0]    write_addr,
    input  logic [word_width-1:0]    write_data,
    output logic                     im_wren,
    output logic [im_addr_width-1:0] im_write_addr,
    output logic [im_word_width-1:0] im_write_data,
    output logic                     od_wren,
    output logic [opcode_width-1:0]  od_write_addr,
    output logic [od_word_width-1:0] od_write_data
);

    localparam logic [addr_width-1:0] im_base  = addr_width'(im_base_addr_write);
    localparam logic [addr_width-1:0] im_bound =
        addr_width'(im_base_addr_write + im_depth - 1);
    localparam logic [addr_width-1:0] od_base  = addr_width'(od_base_addr_write);
    localparam logic [addr_width-1:0] od_bound =
        addr_width'(od_base_addr_write + od_thread_depth - 1);

    logic                  instruction_ok;
    logic                  wen_pipe  [write_retime_stages];
    logic [addr_width-1:0] addr_pipe [write_retime_stages];
    logic [word_width-1:0] data_pipe [write_retime_stages];
    logic                  wen_q;
    logic [addr_width-1:0] addr_q;
    logic [word_width-1:0] data_q;
    logic [addr_width-1:0] im_offset;
    logic [addr_width-1:0] od_offset;

    // A store only counts if the storing instruction issued and was not cancelled
    assign instruction_ok = ior_previous & ~cancel_previous;

    // ----------------------------------------------------------------------
    // Retime enable, address and data together so a store stays coherent
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < write_retime_stages; i++) begin
                wen_pipe[i]  <= 1'b0;
                addr_pipe[i] <= '0;
                data_pipe[i] <= '0;
            end
        end else begin
            wen_pipe[0]  <= instruction_ok;
            addr_pipe[0] <= write_addr;
            data_pipe[0] <= write_data;
            for (int i = 1; i < write_retime_stages; i++) begin
                wen_pipe[i]  <= wen_pipe[i-1];
                addr_pipe[i] <= addr_pipe[i-1];
                data_pipe[i] <= data_pipe[i-1];
            end
        end
    end

    assign wen_q  = wen_pipe[write_retime_stages-1];
    assign addr_q = addr_pipe[write_retime_stages-1];
    assign data_q = data_pipe[write_retime_stages-1];

    // ----------------------------------------------------------------------
    // Window checks on the retimed address
    // ----------------------------------------------------------------------

    assign im_offset = addr_q - im_base;
    assign od_offset = addr_q - od_base;

    assign im_wren       = wen_q && (addr_q >= im_base) && (addr_q <= im_bound);
    assign im_write_addr = im_offset[im_addr_width-1:0];
    assign im_write_data = data_q[im_word_width-1:0];

    assign od_wren       = wen_q && (addr_q >= od_base) && (addr_q <= od_bound);
    assign od_write_addr = od_offset[opcode_width-1:0];
    assign od_write_data = data_q[od_word_width-1:0];

endmodule

/* sources.f */
hw/fetch_decode_pkg.sv
hw/write_address_mapper.sv
hw/instruction_memory.sv
hw/opcode_decoder_memory.sv
hw/instruction_fetch_decode.sv
hw/fetch_decode_mapped.sv
testbench/tb_clock_gen.sv
testbench/tb_fetch_decode_mapped.sv

/* testbench/tb_clock_gen.sv */
// Testbench clock and synchronous active-low reset generator
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 3
)
(
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Reset is released on a rising edge, like any other synchronous input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

/* testbench/tb_fetch_decode_mapped.sv */
// Directed tests of the mapped fetch and decode stage with a reference model and timeout
`timescale 1ns/1ns

module tb_fetch_decode_mapped
    import fetch_decode_pkg::*;
();

    localparam int im_depth                = 64;
    localparam int im_addr_width           = 6;
    localparam int thread_count            = 2;
    localparam int thread_count_width      = 1;
    localparam int od_thread_depth         = 16;
    localparam int im_base_addr_write      = 256;
    localparam int od_base_addr_write      = 512;
    localparam int db_base_addr            = 128;
    localparam int od_initial_thread_read  = 0;
    localparam int od_initial_thread_write = 1;
    localparam int write_retime_stages     = 1;
    // All tests together take about 300 cycles
    localparam int timeout_limit           = 2000;

    logic                       clock;
    logic                       rst_n;
    logic                       ior_previous;
    logic                       cancel_previous;
    logic [addr_width-1:0]      write_addr;
    logic [word_width-1:0]      write_data;
    logic [im_addr_width-1:0]   im_read_addr;
    logic [od_word_width-1:0]   alu_control;
    logic [d_operand_width-1:0] da;
    logic [d_operand_width-1:0] db;
    logic [a_operand_width-1:0] a;
    logic [b_operand_width-1:0] b;

    // Reference contents of both memories and the outstanding fetches
    logic [im_word_width-1:0] im_model [im_depth];
    logic [od_word_width-1:0] od_model [thread_count][od_thread_depth];
    int                       due_q[$];
    logic [im_word_width-1:0] instr_q[$];
    logic [od_word_width-1:0] alu_q[$];

    int seed;
    int cyc;
    int error_count;
    int check_count;
    int timeout_count = 0;

    tb_clock_gen #(
        .period       (40),
        .reset_cycles (3)
    ) tb_clock_gen_inst (
        .clock (clock),
        .rst_n (rst_n)
    );

    fetch_decode_mapped #(
        .im_depth                (im_depth),
        .im_addr_width           (im_addr_width),
        .thread_count            (thread_count),
        .thread_count_width      (thread_count_width),
        .od_thread_depth         (od_thread_depth),
        .im_base_addr_write      (im_base_addr_write),
        .od_base_addr_write      (od_base_addr_write),
        .db_base_addr            (db_base_addr),
        .od_initial_thread_read  (od_initial_thread_read),
        .od_initial_thread_write (od_initial_thread_write),
        .write_retime_stages     (write_retime_stages)
    ) fetch_decode_mapped_inst (
        .clock           (clock),
        .rst_n           (rst_n),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .im_read_addr    (im_read_addr),
        .alu_control     (alu_control),
        .da              (da),
        .db              (db),
        .a               (a),
        .b               (b)
    );

    // ----------------------------------------------------------------------
    // Output comparison and cycle driver
    // ----------------------------------------------------------------------

    task automatic compare_outputs(input logic [od_word_width-1:0] exp_alu,
                                   input logic [d_operand_width-1:0] exp_da,
                                   input logic [d_operand_width-1:0] exp_db,
                                   input logic [a_operand_width-1:0] exp_a,
                                   input logic [b_operand_width-1:0] exp_b);
        check_count = check_count + 1;
        if (alu_control !== exp_alu) begin
            error_count = error_count + 1;
            $display("** Error: alu_control expected %h, got %h", exp_alu, alu_control);
        end
        if (da !== exp_da) begin
            error_count = error_count + 1;
            $display("** Error: da expected %h, got %h", exp_da, da);
        end
        if (db !== exp_db) begin
            error_count = error_count + 1;
            $display("** Error: db expected %h, got %h", exp_db, db);
        end
        if (a !== exp_a) begin
            error_count = error_count + 1;
            $display("** Error: a expected %h, got %h", exp_a, a);
        end
        if (b !== exp_b) begin
            error_count = error_count + 1;
            $display("** Error: b expected %h, got %h", exp_b, b);
        end
    endtask

    // Fields from the top bit down are opcode, D, A, B; DB is D moved into B space
    task automatic check_fetch();
        logic [im_word_width-1:0]   instr;
        logic [od_word_width-1:0]   exp_alu;
        logic [d_operand_width-1:0] exp_d;
        instr   = instr_q.pop_front();
        exp_alu = alu_q.pop_front();
        void'(due_q.pop_front());
        exp_d = instr[b_operand_width + a_operand_width +: d_operand_width];
        compare_outputs(exp_alu, exp_d, exp_d + d_operand_width'(db_base_addr),
                        instr[b_operand_width +: a_operand_width],
                        instr[b_operand_width-1:0]);
    endtask

    // Inputs driven after edge cyc are sampled at cyc+1. A store then lands at
    // cyc+2 and a fetch shows on the outputs after cyc+2
    task automatic drive_cycle(input logic ior, input logic cancel,
                               input logic [addr_width-1:0] addr,
                               input logic [word_width-1:0] data,
                               input logic [im_addr_width-1:0] pc, input logic fetch);
        logic [im_word_width-1:0] instr;
        int                       waddr;
        int                       wr_thread;
        int                       rd_thread;
        @(posedge clock);
        cyc = cyc + 1;
        ior_previous    <= ior;
        cancel_previous <= cancel;
        write_addr      <= addr;
        write_data      <= data;
        im_read_addr    <= pc;
        waddr     = addr;
        wr_thread = (od_initial_thread_write + cyc + 1) % thread_count;
        rd_thread = (od_initial_thread_read + cyc + 1) % thread_count;
        if (ior && !cancel) begin
            if (waddr >= im_base_addr_write && waddr < im_base_addr_write + im_depth) begin
                im_model[waddr - im_base_addr_write] = data[im_word_width-1:0];
            end
            if (waddr >= od_base_addr_write &&
                waddr < od_base_addr_write + od_thread_depth) begin
                od_model[wr_thread][waddr - od_base_addr_write] = data[od_word_width-1:0];
            end
        end
        if (fetch) begin
            instr = im_model[pc];
            due_q.push_back(cyc + 2);
            instr_q.push_back(instr);
            alu_q.push_back(od_model[rd_thread][instr[im_word_width-1 -: opcode_width]]);
        end
        @(negedge clock);
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            check_fetch();
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0);
    endtask

    task automatic write_store(input int addr, input logic [word_width-1:0] data);
        drive_cycle(1'b1, 1'b0, addr_width'(addr), data, '0, 1'b0);
    endtask

    task automatic fetch_pc(input logic [im_addr_width-1:0] pc);
        drive_cycle(1'b0, 1'b0, '0, '0, pc, 1'b1);
    endtask

    // Two spare cycles keep stores apart from later fetches of the same word
    task automatic drain_pipeline();
        while (due_q.size() > 0) begin
            idle_cycle();
        end
        idle_cycle();
        idle_cycle();
    endtask

    function automatic logic [im_word_width-1:0] make_instr(
        input logic [opcode_width-1:0] op, input logic [d_operand_width-1:0] d,
        input logic [a_operand_width-1:0] a_op, input logic [b_operand_width-1:0] b_op);
        return {op, d, a_op, b_op};
    endfunction

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    task automatic test_startup_nop();
        for (int i = 0; i < 3; i++) begin
            idle_cycle();
            compare_outputs('0, '0, '0, '0, '0);
        end
    endtask

    task automatic test_fill_and_fetch();
        logic [63:0] rnd;
        for (int i = 0; i < im_depth; i++) begin
            rnd = {$random(seed), $random(seed)};
            write_store(im_base_addr_write + i, rnd[word_width-1:0]);
        end
        // Back to back stores to one entry fill it in every thread
        for (int j = 0; j < od_thread_depth; j++) begin
            repeat (thread_count) begin
                rnd = {$random(seed), $random(seed)};
                write_store(od_base_addr_write + j, rnd[word_width-1:0]);
            end
        end
        drain_pipeline();
        for (int i = 0; i < im_depth; i++) begin
            fetch_pc(im_addr_width'(i));
        end
        for (int i = 0; i < 32; i++) begin
            rnd = $random(seed);
            fetch_pc(rnd[im_addr_width-1:0]);
        end
        drain_pipeline();
    endtask

    task automatic test_thread_decode();
        write_store(im_base_addr_write + 9, {2'b10, make_instr(4'd9, 10'h155, 10'h2aa, 10'h0f0)});
        write_store(od_base_addr_write + 9, word_width'(20'ha5a5a));
        write_store(od_base_addr_write + 9, word_width'(20'h5a5a5));
        drain_pipeline();
        repeat (6) begin
            fetch_pc(6'd9);
        end
        drain_pipeline();
    endtask

    task automatic test_write_qualification();
        int op;
        op = im_model[3][im_word_width-1 -: opcode_width];
        drive_cycle(1'b0, 1'b0, addr_width'(im_base_addr_write + 3), 36'h0_1234_5678, '0, 1'b0);
        drive_cycle(1'b1, 1'b1, addr_width'(im_base_addr_write + 3), 36'h0_8765_4321, '0, 1'b0);
        drive_cycle(1'b0, 1'b1, addr_width'(im_base_addr_write + 3), 36'h3_ffff_ffff, '0, 1'b0);
        drive_cycle(1'b0, 1'b0, addr_width'(od_base_addr_write + op), 36'h0_000c_0ffe, '0, 1'b0);
        drive_cycle(1'b1, 1'b1, addr_width'(od_base_addr_write + op), 36'h0_000b_eef0, '0, 1'b0);
        drain_pipeline();
        fetch_pc(6'd3);
        fetch_pc(6'd3);
        fetch_pc(6'd4);
        drain_pipeline();
    endtask

    // Stray stores go last, so a wrongly mapped one would overwrite an in-window word
    task automatic test_window_bounds();
        write_store(im_base_addr_write, {2'b01, make_instr(4'd0, 10'h011, 10'h022, 10'h033)});
        write_store(im_base_addr_write + im_depth - 1,
                    {2'b01, make_instr(4'd15, 10'h3fe, 10'h2cc, 10'h1dd)});
        write_store(od_base_addr_write, word_width'(20'h00c01));
        write_store(od_base_addr_write + od_thread_depth - 1, word_width'(20'hf0c0f));
        write_store(im_base_addr_write - 1, 36'h0_5555_5555);
        write_store(im_base_addr_write + im_depth, 36'h0_aaaa_aaaa);
        write_store(od_base_addr_write - 1, word_width'(20'h11111));
        write_store(od_base_addr_write + od_thread_depth, word_width'(20'h22222));
        drain_pipeline();
        fetch_pc(6'd0);
        fetch_pc(6'd0);
        fetch_pc(6'd63);
        fetch_pc(6'd63);
        drain_pipeline();
    endtask

    // ----------------------------------------------------------------------
    // Test sequence and timeout
    // ----------------------------------------------------------------------

    initial begin
        seed            = 43;
        cyc             = 0;
        error_count     = 0;
        check_count     = 0;
        ior_previous    = 1'b0;
        cancel_previous = 1'b0;
        write_addr      = '0;
        write_data      = '0;
        im_read_addr    = '0;
        wait (rst_n === 1'b1);
        test_startup_nop();
        test_fill_and_fetch();
        test_thread_decode();
        test_write_qualification();
        test_window_bounds();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    always @(posedge clock) begin
        timeout_count = timeout_count + 1;
        if (timeout_count >= timeout_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
            $display("test failed");
            $finish;
        end
    end

endmodule
